/* ctl_pkg.sv */
// shared widths, opcode fields and encodings of the control ring, compiled before all modules
package ctl_pkg;

	// instruction word
	localparam int unsigned CODE_W  = 16;                // opcode width
	localparam int unsigned IMM_W   = 8;                 // signed immediate field width
	localparam int unsigned OP_W    = 4;                 // op field width
	localparam int unsigned TST_W   = 3;                 // test field width

	// field positions in the opcode
	localparam int unsigned OP_LSB  = 12;                // op in bits 15..12
	localparam int unsigned TST_LSB = 9;                 // test in bits 11..9
	localparam int unsigned IM_LSB  = 0;                 // immediate in bits 7..0, bit 8 spare

	// PC after reset and after clear-all
	localparam int unsigned PC_RST  = 0;

	// major opcodes, codes 9..15 are illegal
	typedef enum logic [OP_W-1:0] {
		OP_NOP  = 4'd0,                                   // no operation
		OP_ADD  = 4'd1,                                   // add
		OP_SUB  = 4'd2,                                   // subtract
		OP_LIT  = 4'd3,                                   // literal from immediate
		OP_MRD  = 4'd4,                                   // memory read
		OP_MWR  = 4'd5,                                   // memory write
		OP_JMP  = 4'd6,                                   // relative jump
		OP_JMPC = 4'd7,                                   // conditional relative jump
		OP_GTO  = 4'd8                                    // absolute jump to b
	} op_e;

	// branch tests, codes 6 and 7 evaluate false
	typedef enum logic [TST_W-1:0] {
		TST_NZ = 3'd0,                                    // a != 0
		TST_LZ = 3'd1,                                    // a < 0
		TST_OD = 3'd2,                                    // a odd
		TST_NE = 3'd3,                                    // a != b
		TST_LT = 3'd4,                                    // a < b
		TST_AL = 3'd5                                     // always
	} tst_e;

endpackage

/* thread_id_ring.sv */
// thread ID counter for the control ring, gives the issuing thread and the thread in stage 1
`timescale 1ns/1ps

module thread_id_ring #(
	parameter int unsigned THREADS = 4                   // hardware threads, 3 or more
) (
	input  logic                               clk_i,    // clock
	input  logic                               rst_n_i,  // async reset, active low
	output logic [$clog2(THREADS)-1:0]         id_o,     // thread now issuing
	output logic [$clog2(THREADS)-1:0]         id_1_o    // thread in stage 1
);

	localparam int unsigned ID_W = $clog2(THREADS);

	logic [ID_W-1:0] id_nxt;                            // next issuing thread

	// modulo THREADS increment
	always_comb begin
		if (id_o == ID_W'(THREADS - 1)) begin
			id_nxt = '0;                                    // wrap to thread 0
		end else begin
			id_nxt = id_o + 1'b1;
		end
	end

	// issue counter
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			id_o <= '0;                                     // thread 0 issues first
		end else begin
			id_o <= id_nxt;
		end
	end

	// stage 1 tag, one cycle behind the issue counter
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			id_1_o <= ID_W'(THREADS - 1);                   // last thread precedes thread 0
		end else begin
			id_1_o <= id_o;
		end
	end

endmodule

/* tst_decode.sv */
// branch condition tester, picks one ALU flag by test code and registers the decision for stage 1
`timescale 1ns/1ps

module tst_decode (
	input  logic            clk_i,                       // clock
	input  logic            rst_n_i,                     // async reset, active low
	input  ctl_pkg::tst_e   tst_i,                       // test code from the decoder
	input  logic            flg_nz_i,                    // a != 0
	input  logic            flg_lz_i,                    // a < 0
	input  logic            flg_od_i,                    // a odd
	input  logic            flg_ne_i,                    // a != b
	input  logic            flg_lt_i,                    // a < b
	output logic            result_o                     // 1=test true, stage 1
);

	logic tst_res;                                       // unregistered decision

	// flag select
	always_comb begin
		unique case (tst_i)
			ctl_pkg::TST_NZ: begin
				tst_res = flg_nz_i;
			end
			ctl_pkg::TST_LZ: begin
				tst_res = flg_lz_i;
			end
			ctl_pkg::TST_OD: begin
				tst_res = flg_od_i;
			end
			ctl_pkg::TST_NE: begin
				tst_res = flg_ne_i;
			end
			ctl_pkg::TST_LT: begin
				tst_res = flg_lt_i;
			end
			ctl_pkg::TST_AL: begin
				tst_res = 1'b1;                               // unconditional
			end
			default: begin
				tst_res = 1'b0;                               // spare codes never pass
			end
		endcase
	end

	// align with the registered decode outputs
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			result_o <= 1'b0;
		end else begin
			result_o <= tst_res;
		end
	end

endmodule

/* op_decode.sv */
// opcode decoder, turns the issuing opcode into registered strobes and branch flags for stage 1
`timescale 1ns/1ps

module op_decode #(
	parameter int unsigned PC_W = 12                     // PC width, IMM_W to CODE_W
) (
	input  logic                          clk_i,         // clock
	input  logic                          rst_n_i,       // async reset, active low
	input  logic [ctl_pkg::CODE_W-1:0]    opcode_i,      // opcode of the issuing thread
	input  logic [ctl_pkg::CODE_W-1:0]    b_i,           // b operand of the issuing thread
	output logic                          add_o,         // 1=add
	output logic                          sub_o,         // 1=subtract
	output logic                          lit_o,         // 1=literal
	output logic                          mem_rd_o,      // 1=memory read
	output logic                          mem_wr_o,      // 1=memory write
	output logic                          op_er_o,       // 1=illegal opcode
	output logic [PC_W-1:0]               im_o,          // sign extended immediate
	output logic                          jmp_o,         // 1=relative jump
	output logic                          cnd_o,         // 1=conditional jump
	output logic                          gto_o,         // 1=absolute jump
	output logic [PC_W-1:0]               b_o,           // b held for gto
	output ctl_pkg::tst_e                 tst_o          // test field, unregistered
);

	ctl_pkg::op_e   op;                                  // major opcode field
	logic [ctl_pkg::IMM_W-1:0] im_fld;                   // raw immediate
	logic           add_d, sub_d, lit_d;                 // next strobes
	logic           mem_rd_d, mem_wr_d, op_er_d;
	logic           jmp_d, cnd_d, gto_d;

	// field extraction
	assign op     = ctl_pkg::op_e'(opcode_i[ctl_pkg::OP_LSB +: ctl_pkg::OP_W]);
	assign tst_o  = ctl_pkg::tst_e'(opcode_i[ctl_pkg::TST_LSB +: ctl_pkg::TST_W]);
	assign im_fld = opcode_i[ctl_pkg::IM_LSB +: ctl_pkg::IMM_W];

	// one strobe or branch flag per legal op
	always_comb begin
		add_d    = 1'b0;
		sub_d    = 1'b0;
		lit_d    = 1'b0;
		mem_rd_d = 1'b0;
		mem_wr_d = 1'b0;
		op_er_d  = 1'b0;
		jmp_d    = 1'b0;
		cnd_d    = 1'b0;
		gto_d    = 1'b0;
		unique case (op)
			ctl_pkg::OP_NOP: begin
			end                                             // pc + 1 only
			ctl_pkg::OP_ADD: begin
				add_d = 1'b1;
			end
			ctl_pkg::OP_SUB: begin
				sub_d = 1'b1;
			end
			ctl_pkg::OP_LIT: begin
				lit_d = 1'b1;                                 // data from im_o
			end
			ctl_pkg::OP_MRD: begin
				mem_rd_d = 1'b1;
			end
			ctl_pkg::OP_MWR: begin
				mem_wr_d = 1'b1;
			end
			ctl_pkg::OP_JMP: begin
				jmp_d = 1'b1;
			end
			ctl_pkg::OP_JMPC: begin
				cnd_d = 1'b1;                                 // qualified by tst_decode
			end
			ctl_pkg::OP_GTO: begin
				gto_d = 1'b1;
			end
			default: begin
				op_er_d = 1'b1;                               // flag alone, pc + 1
			end
		endcase
	end

	// control strobes
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			add_o    <= 1'b0;
			sub_o    <= 1'b0;
			lit_o    <= 1'b0;
			mem_rd_o <= 1'b0;
			mem_wr_o <= 1'b0;
			op_er_o  <= 1'b0;
			jmp_o    <= 1'b0;
			cnd_o    <= 1'b0;
			gto_o    <= 1'b0;
		end else begin
			add_o    <= add_d;
			sub_o    <= sub_d;
			lit_o    <= lit_d;
			mem_rd_o <= mem_rd_d;
			mem_wr_o <= mem_wr_d;
			op_er_o  <= op_er_d;
			jmp_o    <= jmp_d;
			cnd_o    <= cnd_d;
			gto_o    <= gto_d;
		end
	end

	// payload
	always_ff @(posedge clk_i) begin
		im_o <= PC_W'($signed(im_fld));                    // sign extend to PC width
		b_o  <= b_i[PC_W-1:0];                             // truncate to PC width
	end

endmodule

/* pc_ring.sv */
// per-thread PC storage, presents the issuing thread's PC and writes back its next PC in stage 1
`timescale 1ns/1ps

module pc_ring #(
	parameter int unsigned THREADS = 4,                  // hardware threads, 3 or more
	parameter int unsigned PC_W    = 12                  // PC width
) (
	input  logic                          clk_i,         // clock
	input  logic                          rst_n_i,       // async reset, active low
	input  logic                          cla_i,         // clear all threads
	input  logic [$clog2(THREADS)-1:0]    id_1_i,        // thread in stage 1
	input  logic                          jmp_i,         // 1=relative jump
	input  logic                          cnd_i,         // 1=conditional jump
	input  logic                          gto_i,         // 1=absolute jump
	input  logic                          tst_res_i,     // 1=test true
	input  logic [PC_W-1:0]               im_i,          // sign extended offset
	input  logic [PC_W-1:0]               b_i,           // absolute target
	output logic [PC_W-1:0]               pc_o           // PC of the issuing thread
);

	localparam int unsigned ID_W = $clog2(THREADS);

	logic [PC_W-1:0] pc_q [THREADS];                     // one PC per thread
	logic [ID_W-1:0] rd_id;                              // issuing thread
	logic [PC_W-1:0] pc_1;                               // stage 1 held PC
	logic            vld_1;                              // stage 1 holds a live PC
	logic [PC_W-1:0] pc_nxt;                             // next PC for stage 1 thread

	// issuing thread is the one after stage 1
	always_comb begin
		if (id_1_i == ID_W'(THREADS - 1)) begin
			rd_id = '0;
		end else begin
			rd_id = id_1_i + 1'b1;
		end
	end

	assign pc_o = pc_q[rd_id];                           // head of the ring

	// stage 1 register
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_1  <= PC_W'(ctl_pkg::PC_RST);
			vld_1 <= 1'b0;                                  // nothing issued yet
		end else if (cla_i) begin
			pc_1  <= PC_W'(ctl_pkg::PC_RST);
			vld_1 <= 1'b0;                                  // drop in flight update
		end else begin
			pc_1  <= pc_o;
			vld_1 <= 1'b1;
		end
	end

	// next PC select
	always_comb begin
		if (gto_i) begin
			pc_nxt = b_i;                                   // absolute
		end else if (jmp_i || (cnd_i && tst_res_i)) begin
			pc_nxt = pc_1 + im_i;                           // relative, wraps mod 2^PC_W
		end else begin
			pc_nxt = pc_1 + 1'b1;                           // sequential and illegal ops
		end
	end

	// ring storage, written back THREADS-1 cycles before the next visit
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int t = 0; t < THREADS; t++) begin
				pc_q[t] <= PC_W'(ctl_pkg::PC_RST);
			end
		end else if (cla_i) begin
			for (int t = 0; t < THREADS; t++) begin
				pc_q[t] <= PC_W'(ctl_pkg::PC_RST);            // all threads restart
			end
		end else if (vld_1) begin
			pc_q[id_1_i] <= pc_nxt;
		end
	end

endmodule

/* control_ring.sv */
// top of the barrel-threaded control path, one thread issues per clock in strict rotation
`timescale 1ns/1ps

module control_ring #(
	parameter int unsigned THREADS = 4,                  // hardware threads, 3 or more
	parameter int unsigned PC_W    = 12                  // PC width, IMM_W to CODE_W
) (
	// clock and reset
	input  logic                          clk_i,         // clock
	input  logic                          rst_n_i,       // async reset, active low
	// control
	input  logic                          cla_i,         // clear all threads
	input  logic [ctl_pkg::CODE_W-1:0]    opcode_i,      // opcode of thread id_o
	input  logic [ctl_pkg::CODE_W-1:0]    b_i,           // b operand of thread id_o
	// flags of thread id_o
	input  logic                          flg_nz_i,      // a != 0
	input  logic                          flg_lz_i,      // a < 0
	input  logic                          flg_od_i,      // a odd
	input  logic                          flg_ne_i,      // a != b
	input  logic                          flg_lt_i,      // a < b
	// thread and address
	output logic [$clog2(THREADS)-1:0]    id_o,          // issuing thread
	output logic [PC_W-1:0]               pc_o,          // its PC
	// strobes, one cycle after issue
	output logic                          add_o,         // 1=add
	output logic                          sub_o,         // 1=subtract
	output logic                          lit_o,         // 1=literal
	output logic                          mem_rd_o,      // 1=memory read
	output logic                          mem_wr_o,      // 1=memory write
	output logic [PC_W-1:0]               im_o,          // sign extended immediate
	output logic                          op_er_o        // 1=illegal opcode
);

	logic [$clog2(THREADS)-1:0] id_1;                    // stage 1 thread
	ctl_pkg::tst_e              tst;                     // test code to tester
	logic                       tst_res;                 // stage 1 decision
	logic                       jmp, cnd, gto;           // stage 1 branch type
	logic [PC_W-1:0]            b_pc;                    // stage 1 gto target

	// thread tags
	thread_id_ring #(.THREADS(THREADS)) u_id_ring (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.id_o    (id_o),
		.id_1_o  (id_1)
	);

	// branch condition
	tst_decode u_tst_decode (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.tst_i    (tst),
		.flg_nz_i (flg_nz_i),
		.flg_lz_i (flg_lz_i),
		.flg_od_i (flg_od_i),
		.flg_ne_i (flg_ne_i),
		.flg_lt_i (flg_lt_i),
		.result_o (tst_res)
	);

	// opcode decode
	op_decode #(.PC_W(PC_W)) u_op_decode (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.opcode_i (opcode_i),
		.b_i      (b_i),
		.add_o    (add_o),
		.sub_o    (sub_o),
		.lit_o    (lit_o),
		.mem_rd_o (mem_rd_o),
		.mem_wr_o (mem_wr_o),
		.op_er_o  (op_er_o),
		.im_o     (im_o),
		.jmp_o    (jmp),
		.cnd_o    (cnd),
		.gto_o    (gto),
		.b_o      (b_pc),
		.tst_o    (tst)
	);

	// pc storage and update
	pc_ring #(.THREADS(THREADS), .PC_W(PC_W)) u_pc_ring (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.cla_i     (cla_i),
		.id_1_i    (id_1),
		.jmp_i     (jmp),
		.cnd_i     (cnd),
		.gto_i     (gto),
		.tst_res_i (tst_res),
		.im_i      (im_o),
		.b_i       (b_pc),
		.pc_o      (pc_o)
	);

endmodule

/* tb_control_ring.sv */
// testbench that drives control_ring from a stimulus table, one issuing thread per row, and checks PCs and strobes
`timescale 1ns/1ps

module tb_control_ring;

	localparam int THREADS    = 4;                       // hardware threads
	localparam int PC_W       = 12;                      // PC width
	localparam int CLK_PERIOD = 8;                       // ns
	localparam int MAX_ROWS   = 128;                     // table capacity
	localparam logic [5:0] S_NONE = 6'b000000;           // {add, sub, lit, mem_rd, mem_wr, op_er}
	localparam logic [5:0] S_ADD  = 6'b100000;
	localparam logic [5:0] S_SUB  = 6'b010000;
	localparam logic [5:0] S_LIT  = 6'b001000;
	localparam logic [5:0] S_MRD  = 6'b000100;
	localparam logic [5:0] S_MWR  = 6'b000010;
	localparam logic [5:0] S_ERR  = 6'b000001;

	logic                       clk_i, rst_n_i, cla_i;
	logic [15:0]                opcode_i, b_i;
	logic                       flg_nz_i, flg_lz_i, flg_od_i, flg_ne_i, flg_lt_i;
	logic [$clog2(THREADS)-1:0] id_o;
	logic [PC_W-1:0]            pc_o, im_o;
	logic                       add_o, sub_o, lit_o, mem_rd_o, mem_wr_o, op_er_o;
	logic [5:0]                 strb_act;                // strobes as one vector

	// stimulus table with flags as {nz, lz, od, ne, lt}
	logic [15:0]     row_op   [MAX_ROWS];
	logic [4:0]      row_flg  [MAX_ROWS];
	logic [15:0]     row_b    [MAX_ROWS];
	logic            row_cla  [MAX_ROWS];
	logic [5:0]      row_strb [MAX_ROWS];                // expected strobes one cycle later
	string           row_name [MAX_ROWS];
	int              n_rows      = 0;
	logic            table_ready = 1'b0;                 // starts the watchdog

	logic [PC_W-1:0] model_pc [THREADS];                 // reference PC per thread
	int              exp_id   = 0;                       // thread expected at id_o
	int              errors   = 0;
	int              checks   = 0;
	logic [31:0]     lfsr     = 32'd92108;               // random source

	assign strb_act = {add_o, sub_o, lit_o, mem_rd_o, mem_wr_o, op_er_o};

	control_ring #(.THREADS(THREADS), .PC_W(PC_W)) uut (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .cla_i(cla_i), .opcode_i(opcode_i), .b_i(b_i),
		.flg_nz_i(flg_nz_i), .flg_lz_i(flg_lz_i), .flg_od_i(flg_od_i),
		.flg_ne_i(flg_ne_i), .flg_lt_i(flg_lt_i),
		.id_o(id_o), .pc_o(pc_o), .add_o(add_o), .sub_o(sub_o), .lit_o(lit_o),
		.mem_rd_o(mem_rd_o), .mem_wr_o(mem_wr_o), .im_o(im_o), .op_er_o(op_er_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;         // 8 ns period
	end

	// one right shifting galois step
	function automatic logic [31:0] galois_step(input logic [31:0] s);
		if (s[0]) begin
			galois_step = (s >> 1) ^ 32'hB4BC_D35C;
		end else begin
			galois_step = s >> 1;
		end
	endfunction

	// collect n random bits with one lfsr step per bit
	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			v    = {v[14:0], lfsr[0]};
			lfsr = galois_step(lfsr);
		end
	endtask

	// opcode word {op, tst, spare, imm}
	function automatic logic [15:0] make_op(input logic [3:0] op, input logic [2:0] tst,
			input logic [7:0] imm);
		make_op = {op, tst, 1'b0, imm};
	endfunction

	function automatic logic [PC_W-1:0] sext_imm(input logic [15:0] opc);
		sext_imm = {{(PC_W - 8){opc[7]}}, opc[7:0]};
	endfunction

	// branch condition from the test code
	function automatic logic test_true(input logic [2:0] tst, input logic [4:0] flg);
		case (tst)
			ctl_pkg::TST_NZ: test_true = flg[4];
			ctl_pkg::TST_LZ: test_true = flg[3];
			ctl_pkg::TST_OD: test_true = flg[2];
			ctl_pkg::TST_NE: test_true = flg[1];
			ctl_pkg::TST_LT: test_true = flg[0];
			ctl_pkg::TST_AL: test_true = 1'b1;
			default:         test_true = 1'b0;           // spare codes
		endcase
	endfunction

	// reference next PC
	function automatic logic [PC_W-1:0] next_pc(input logic [PC_W-1:0] pc,
			input logic [15:0] opc, input logic [4:0] flg, input logic [15:0] b);
		case (opc[15:12])
			ctl_pkg::OP_JMP:  next_pc = pc + sext_imm(opc);
			ctl_pkg::OP_JMPC: next_pc = test_true(opc[11:9], flg) ? pc + sext_imm(opc) : pc + 1;
			ctl_pkg::OP_GTO:  next_pc = b[PC_W-1:0];
			default:          next_pc = pc + 1;          // includes illegal codes
		endcase
	endfunction

	task automatic add_row(input string name, input logic [15:0] opc, input logic [4:0] flg,
			input logic [15:0] b, input logic cla, input logic [5:0] strb);
		row_name[n_rows] = name;
		row_op[n_rows]   = opc;
		row_flg[n_rows]  = flg;
		row_b[n_rows]    = b;
		row_cla[n_rows]  = cla;
		row_strb[n_rows] = strb;
		n_rows++;
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	task automatic build_table();
		logic [15:0] v;
		logic [15:0] f;
		logic [4:0]  sel;
		logic [3:0]  op;
		logic [5:0]  m;
		string       nm;
		for (int k = 0; k <= THREADS; k++) begin
			add_row("reset_idle", 16'h0000, 5'b0, 16'h0, 1'b0, S_NONE);   // id and pc after reset
		end
		for (int r = 0; r < 12; r++) begin
			case (r % 6)
				0: begin
					op = ctl_pkg::OP_NOP;
					m  = S_NONE;
					nm = "seq_nop";
				end
				1: begin
					op = ctl_pkg::OP_ADD;
					m  = S_ADD;
					nm = "seq_add";
				end
				2: begin
					op = ctl_pkg::OP_SUB;
					m  = S_SUB;
					nm = "seq_sub";
				end
				3: begin
					op = ctl_pkg::OP_LIT;
					m  = S_LIT;
					nm = "seq_lit";
				end
				4: begin
					op = ctl_pkg::OP_MRD;
					m  = S_MRD;
					nm = "seq_mrd";
				end
				default: begin
					op = ctl_pkg::OP_MWR;
					m  = S_MWR;
					nm = "seq_mwr";
				end
			endcase
			take_bits(8, v);                             // random immediate
			add_row(nm, make_op(op, 3'd0, v[7:0]), 5'b0, 16'h0, 1'b0, m);
		end
		add_row("jmp_pos", make_op(ctl_pkg::OP_JMP, 3'd0, 8'h05), 5'b0, 16'h0, 1'b0, S_NONE);
		add_row("nop_other", 16'h0000, 5'b0, 16'h0, 1'b0, S_NONE);
		add_row("gto_b", make_op(ctl_pkg::OP_GTO, 3'd0, 8'h00), 5'b0, 16'h0123, 1'b0, S_NONE);
		add_row("jmp_neg", make_op(ctl_pkg::OP_JMP, 3'd0, 8'hFD), 5'b0, 16'h0, 1'b0, S_NONE);
		add_row("jmp_neg_min", make_op(ctl_pkg::OP_JMP, 3'd0, 8'h80), 5'b0, 16'h0, 1'b0,
			S_NONE);
		add_row("gto_trunc", make_op(ctl_pkg::OP_GTO, 3'd0, 8'h00), 5'b0, 16'hABCD, 1'b0,
			S_NONE);                                     // upper bits dropped
		for (int t = 0; t < 8; t++) begin
			sel = (t < 5) ? 5'b10000 >> t : 5'b00000;    // flag read by test t
			for (int r = 0; r < 3; r++) begin
				take_bits(5, f);                         // flags
				take_bits(8, v);                         // offset
				if (r == 0) begin
					f[4:0] = sel;                        // tested flag alone set
				end else if (r == 1) begin
					f[4:0] = ~sel;                       // all flags but the tested one
				end
				if (v[7:0] == 8'h01) begin
					v[7:0] = 8'h41;                      // offset 1 would hide the decision
				end
				add_row($sformatf("jmpc_tst%0d", t), make_op(ctl_pkg::OP_JMPC, 3'(t), v[7:0]),
					f[4:0], 16'h0, 1'b0, S_NONE);
			end
		end
		for (int c = 9; c < 16; c++) begin
			add_row($sformatf("illegal_%0d", c), make_op(4'(c), 3'd0, 8'h11), 5'b0, 16'h0,
				1'b0, S_ERR);
		end
		add_row("jmp_in_flight", make_op(ctl_pkg::OP_JMP, 3'd0, 8'h20), 5'b0, 16'h0, 1'b0,
			S_NONE);                                     // discarded by the clear
		add_row("clear_all", 16'h0000, 5'b0, 16'h0, 1'b1, S_NONE);
		for (int k = 0; k <= THREADS; k++) begin
			add_row("after_clear", make_op(ctl_pkg::OP_ADD, 3'd0, 8'h00), 5'b0, 16'h0, 1'b0,
				S_ADD);
		end
		for (int k = 0; k < THREADS; k++) begin
			add_row("final_visit", 16'h0000, 5'b0, 16'h0, 1'b0, S_NONE);
		end
	endtask

	// watchdog sized from the table length
	initial begin
		wait (table_ready);
		#((n_rows + THREADS + 20) * CLK_PERIOD);
		$display("watchdog: the test loop did not finish in the expected time");
		$display("Regression failed");
		$finish;
	end

	initial begin
		rst_n_i  = 1'b0;
		cla_i    = 1'b0;
		opcode_i = '0;
		b_i      = '0;
		{flg_nz_i, flg_lz_i, flg_od_i, flg_ne_i, flg_lt_i} = '0;
		for (int t = 0; t < THREADS; t++) begin
			model_pc[t] = PC_W'(ctl_pkg::PC_RST);
		end
		build_table();
		table_ready = 1'b1;
		repeat (5) @(posedge clk_i);                     // reset for 5 cycles
		@(negedge clk_i);
		rst_n_i = 1'b1;
		for (int i = 0; i < n_rows; i++) begin
			check({row_name[i], " id"}, 32'(exp_id), 32'(id_o));
			check({row_name[i], " pc"}, 32'(model_pc[exp_id]), 32'(pc_o));
			if (i == 0) begin
				check("reset strobes", 32'(S_NONE), 32'(strb_act));
			end else begin
				check({row_name[i-1], " strobes"}, 32'(row_strb[i-1]), 32'(strb_act));
				check({row_name[i-1], " im"}, 32'(sext_imm(row_op[i-1])), 32'(im_o));
			end
			opcode_i = row_op[i];                        // drive on the falling edge
			b_i      = row_b[i];
			cla_i    = row_cla[i];
			{flg_nz_i, flg_lz_i, flg_od_i, flg_ne_i, flg_lt_i} = row_flg[i];
			if (row_cla[i]) begin
				for (int t = 0; t < THREADS; t++) begin
					model_pc[t] = PC_W'(ctl_pkg::PC_RST); // pending update dropped too
				end
			end else begin
				model_pc[exp_id] = next_pc(model_pc[exp_id], row_op[i], row_flg[i], row_b[i]);
			end
			exp_id = (exp_id + 1) % THREADS;
			@(negedge clk_i);
		end
		check({row_name[n_rows-1], " strobes"}, 32'(row_strb[n_rows-1]), 32'(strb_act));
		check({row_name[n_rows-1], " im"}, 32'(sext_imm(row_op[n_rows-1])), 32'(im_o));
		$display("errors: %0d in %0d checks over %0d rows", errors, checks, n_rows);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* filelist.f */
ctl_pkg.sv
thread_id_ring.sv
tst_decode.sv
op_decode.sv
pc_ring.sv
control_ring.sv
tb_control_ring.sv

/* Bender.yml */
package:
  name: control_ring

sources:
  - ctl_pkg.sv
  - thread_id_ring.sv
  - tst_decode.sv
  - op_decode.sv
  - pc_ring.sv
  - control_ring.sv
  - target: simulation
    files:
      - tb_control_ring.sv
